// File: include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address split of the direct-mapped cache
`define DC_ADDR_BITS   16
`define DC_INDEX_BITS  4                    // 16 lines
`define DC_LINE_BITS   4                    // 16 bytes per line
`define DC_WORD_BITS   32                   // cpu word

`define DC_TAG_BITS    (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_LINE_BITS)

// derived line and word sizes
`define DC_LINE_BYTES  (1 << `DC_LINE_BITS)
`define DC_LINE_WIDTH  (8 * `DC_LINE_BYTES)
`define DC_WORD_BYTES  (`DC_WORD_BITS / 8)
`define DC_WSEL_BITS   (`DC_LINE_BITS - $clog2(`DC_WORD_BYTES))   // word index within a line

`endif

// File: hw/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    // address seen as tag / index / offset
    typedef struct packed {
        logic [`DC_TAG_BITS-1:0]   tag;
        logic [`DC_INDEX_BITS-1:0] index;
        logic [`DC_LINE_BITS-1:0]  offset;     // upper bits pick the word
    } dc_addr_fields_t;

    // same 16 bits, flat or split
    typedef union packed {
        logic [`DC_ADDR_BITS-1:0] raw;
        dc_addr_fields_t          fld;
    } dc_addr_u;

    // line state kept next to the tag
    typedef struct packed {
        logic valid;                          // line holds memory data
        logic modified;                       // cpu wrote it since refill
    } dc_flags_t;

    typedef struct packed {
        logic                        we;
        dc_addr_u                    addr;
        logic [`DC_WORD_BITS-1:0]    wdata;
        logic [`DC_WORD_BYTES-1:0]   wstrb;
    } dc_cpu_req_t;

    typedef struct packed {
        logic [`DC_WORD_BITS-1:0] rdata;
    } dc_cpu_rsp_t;

    // line reads use an aligned addr with zero wdata and wstrb
    typedef struct packed {
        logic                        we;
        dc_addr_u                    addr;
        logic [`DC_WORD_BITS-1:0]    wdata;
        logic [`DC_WORD_BYTES-1:0]   wstrb;
    } dc_mem_req_t;

    typedef struct packed {
        logic [`DC_LINE_WIDTH-1:0] line;
    } dc_mem_rsp_t;

endpackage

// File: hw/ram_sync.sv
`timescale 1ns/1ps

// single-port synchronous ram, old data comes out on a write
module ram_sync #(
    parameter int ABITS = 4,
    parameter int DBITS = 10
) (
    input  logic             i_clk,
    input  logic [ABITS-1:0] i_addr,
    input  logic             i_we,
    input  logic [DBITS-1:0] i_wdata,
    output logic [DBITS-1:0] o_rdata
);

    logic [DBITS-1:0] mem [2**ABITS];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];           // read before write
    end

endmodule

// File: hw/ram_sync_bwe.sv
`timescale 1ns/1ps

// synchronous ram with one write enable per byte lane
module ram_sync_bwe #(
    parameter int ABITS  = 4,
    parameter int DBYTES = 16
) (
    input  logic                  i_clk,
    input  logic [ABITS-1:0]      i_addr,
    input  logic [DBYTES-1:0]     i_wstrb,
    input  logic [DBYTES*8-1:0]   i_wdata,
    output logic [DBYTES*8-1:0]   o_rdata
);

    logic [DBYTES*8-1:0] mem [2**ABITS];

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < DBYTES; b++) begin
            if (i_wstrb[b]) begin
                mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
            end
        end
        o_rdata <= mem[i_addr];
    end

endmodule

// File: hw/tag_mem.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tag_mem (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  dcache_pkg::dc_addr_u          i_addr,
    input  logic [`DC_LINE_BYTES-1:0]     i_wstrb,
    input  logic [`DC_LINE_WIDTH-1:0]     i_wline,
    input  dcache_pkg::dc_flags_t         i_wflags,
    input  dcache_pkg::dc_addr_u          i_snoop_addr,
    output dcache_pkg::dc_addr_u          o_raddr,
    output logic [`DC_LINE_WIDTH-1:0]     o_rline,
    output dcache_pkg::dc_flags_t         o_rflags,
    output logic                          o_hit,
    output dcache_pkg::dc_flags_t         o_snoop_flags
);

    // tag ram word is {flags, tag}
    localparam int TFW = `DC_TAG_BITS + $bits(dcache_pkg::dc_flags_t);

    logic [`DC_INDEX_BITS-1:0] index;
    logic [`DC_INDEX_BITS-1:0] snoop_index;
    logic                      tag_we;
    logic [TFW-1:0]            tag_wdata;
    logic [TFW-1:0]            tag_rdata;
    logic [TFW-1:0]            snoop_rdata;
    dcache_pkg::dc_flags_t     snoop_flags;

    logic [`DC_TAG_BITS-1:0]   r_tag;         // tag of the pending lookup
    logic [`DC_INDEX_BITS-1:0] r_index;
    logic [`DC_TAG_BITS-1:0]   r_snoop_tag;

    assign index     = i_addr.fld.index;
    assign tag_we    = |i_wstrb;              // any byte written updates tag and flags
    assign tag_wdata = {i_wflags, i_addr.fld.tag};

    // the write borrows the snoop ram port so both copies stay equal
    assign snoop_index = tag_we ? index : i_snoop_addr.fld.index;

    ram_sync_bwe #(
        .ABITS  (`DC_INDEX_BITS),
        .DBYTES (`DC_LINE_BYTES)
    ) data_ram (
        .i_clk   (i_clk),
        .i_addr  (index),
        .i_wstrb (i_wstrb),
        .i_wdata (i_wline),
        .o_rdata (o_rline)
    );

    ram_sync #(
        .ABITS (`DC_INDEX_BITS),
        .DBITS (TFW)
    ) tag_ram (
        .i_clk   (i_clk),
        .i_addr  (index),
        .i_we    (tag_we),
        .i_wdata (tag_wdata),
        .o_rdata (tag_rdata)
    );

    ram_sync #(
        .ABITS (`DC_INDEX_BITS),
        .DBITS (TFW)
    ) snoop_tag_ram (
        .i_clk   (i_clk),
        .i_addr  (snoop_index),
        .i_we    (tag_we),
        .i_wdata (tag_wdata),
        .o_rdata (snoop_rdata)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_tag       <= '0;
            r_index     <= '0;
            r_snoop_tag <= '0;
        end else begin
            r_tag       <= i_addr.fld.tag;
            r_index     <= index;
            r_snoop_tag <= i_snoop_addr.fld.tag;
        end
    end

    assign o_rflags = tag_rdata[TFW-1:`DC_TAG_BITS];
    assign o_hit    = (tag_rdata[`DC_TAG_BITS-1:0] == r_tag) && o_rflags.valid;

    // stored line address, offset always zero
    always_comb begin
        o_raddr           = '0;
        o_raddr.fld.tag   = tag_rdata[`DC_TAG_BITS-1:0];
        o_raddr.fld.index = r_index;
    end

    assign snoop_flags   = snoop_rdata[TFW-1:`DC_TAG_BITS];
    assign o_snoop_flags = (snoop_rdata[`DC_TAG_BITS-1:0] == r_snoop_tag) ? snoop_flags : '0;

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_cpu_req,
    input  dcache_pkg::dc_cpu_req_t       i_cpu_req_data,
    output logic                          o_cpu_ack,
    output dcache_pkg::dc_cpu_rsp_t       o_cpu_rsp,
    output logic                          o_mem_req,
    output dcache_pkg::dc_mem_req_t       o_mem_req_data,
    input  logic                          i_mem_ack,
    input  dcache_pkg::dc_mem_rsp_t       i_mem_rsp,
    output dcache_pkg::dc_addr_u          o_tm_addr,
    output logic [`DC_LINE_BYTES-1:0]     o_tm_wstrb,
    output logic [`DC_LINE_WIDTH-1:0]     o_tm_wline,
    output dcache_pkg::dc_flags_t         o_tm_wflags,
    input  logic                          i_tm_hit,
    input  dcache_pkg::dc_flags_t         i_tm_rflags,
    input  logic [`DC_LINE_WIDTH-1:0]     i_tm_rline
);

    localparam int LINE_BYTES = `DC_LINE_BYTES;
    localparam int LINE_W     = `DC_LINE_WIDTH;
    localparam int WORD_BYTES = `DC_WORD_BYTES;

    typedef enum logic [2:0] {
        CLEAR,
        IDLE,
        LOOKUP,
        REFILL,
        FILL_WR,
        WR_HIT,
        WR_MEM,
        ACK
    } state_t;

    state_t                     state;
    logic [`DC_INDEX_BITS-1:0]  r_clr_idx;        // sweep pointer after reset
    logic                       r_lk_phase;       // 0 address cycle, 1 compare cycle
    dcache_pkg::dc_cpu_req_t    r_req;
    logic [LINE_W-1:0]          r_line;
    logic [`DC_WORD_BITS-1:0]   r_rdata;
    logic [`DC_WSEL_BITS-1:0]   wsel;
    logic                       lookup_done;

    assign wsel        = r_req.addr.fld.offset[`DC_LINE_BITS-1 -: `DC_WSEL_BITS];
    assign lookup_done = (state == LOOKUP) && r_lk_phase;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state      <= CLEAR;
            r_clr_idx  <= '0;
            r_lk_phase <= 1'b0;
            o_cpu_ack  <= 1'b0;
            o_mem_req  <= 1'b0;
        end else begin
            case (state)
                CLEAR: begin
                    r_clr_idx <= r_clr_idx + 1'b1;
                    if (&r_clr_idx) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    r_lk_phase <= 1'b0;
                    if (i_cpu_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    r_lk_phase <= ~r_lk_phase;
                    if (r_lk_phase) begin
                        if (r_req.we) begin
                            if (i_tm_hit) begin
                                state <= WR_HIT;
                            end else begin
                                state     <= WR_MEM;     // write miss, no allocate
                                o_mem_req <= 1'b1;
                            end
                        end else if (i_tm_hit) begin
                            state     <= ACK;
                            o_cpu_ack <= 1'b1;
                        end else begin
                            state     <= REFILL;
                            o_mem_req <= 1'b1;
                        end
                    end
                end
                REFILL: begin
                    if (o_mem_req) begin
                        if (i_mem_ack) begin
                            o_mem_req <= 1'b0;
                        end
                    end else if (!i_mem_ack) begin
                        state <= FILL_WR;              // memory handshake closed
                    end
                end
                FILL_WR: state <= LOOKUP;              // look up again, now a hit
                WR_HIT: begin
                    state     <= WR_MEM;
                    o_mem_req <= 1'b1;
                end
                WR_MEM: begin
                    if (o_mem_req) begin
                        if (i_mem_ack) begin
                            o_mem_req <= 1'b0;
                        end
                    end else if (!i_mem_ack) begin
                        state     <= ACK;
                        o_cpu_ack <= 1'b1;
                    end
                end
                ACK: begin
                    if (!i_cpu_req) begin
                        state     <= IDLE;
                        o_cpu_ack <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request, refill line and read word
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_cpu_req) begin
            r_req <= i_cpu_req_data;
        end
        if (state == REFILL && o_mem_req && i_mem_ack) begin
            r_line <= i_mem_rsp.line;
        end
        if (lookup_done && i_tm_hit && !r_req.we) begin
            r_rdata <= i_tm_rline[wsel*`DC_WORD_BITS +: `DC_WORD_BITS];
        end
    end

    assign o_cpu_rsp.rdata = r_rdata;

    // tag memory access per state
    always_comb begin
        o_tm_addr   = r_req.addr;
        o_tm_wstrb  = '0;
        o_tm_wline  = '0;
        o_tm_wflags = '0;
        case (state)
            CLEAR: begin
                o_tm_addr           = '0;
                o_tm_addr.fld.index = r_clr_idx;
                o_tm_wstrb          = '1;          // flags written as zero
            end
            FILL_WR: begin
                o_tm_wstrb        = '1;
                o_tm_wline        = r_line;
                o_tm_wflags.valid = 1'b1;
            end
            WR_HIT: begin
                // cpu word and strobes moved to their lane in the line
                o_tm_wstrb           = LINE_BYTES'(r_req.wstrb) << (wsel * WORD_BYTES);
                o_tm_wline           = LINE_W'(r_req.wdata) << (wsel * `DC_WORD_BITS);
                o_tm_wflags.valid    = i_tm_rflags.valid;
                o_tm_wflags.modified = 1'b1;
            end
            default: ;
        endcase
    end

    // write goes through as is, read asks for the whole line
    always_comb begin
        o_mem_req_data.we    = r_req.we;
        o_mem_req_data.addr  = r_req.addr;
        o_mem_req_data.wdata = r_req.wdata;
        o_mem_req_data.wstrb = r_req.wstrb;
        if (!r_req.we) begin
            o_mem_req_data.addr.fld.offset = '0;
            o_mem_req_data.wdata           = '0;
            o_mem_req_data.wstrb           = '0;
        end
    end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    // cpu port
    input  logic                      i_cpu_req,
    input  dcache_pkg::dc_cpu_req_t   i_cpu_req_data,
    output logic                      o_cpu_ack,
    output dcache_pkg::dc_cpu_rsp_t   o_cpu_rsp,
    // backing memory port
    output logic                      o_mem_req,
    output dcache_pkg::dc_mem_req_t   o_mem_req_data,
    input  logic                      i_mem_ack,
    input  dcache_pkg::dc_mem_rsp_t   i_mem_rsp,
    // snoop port
    input  dcache_pkg::dc_addr_u      i_snoop_addr,
    output dcache_pkg::dc_flags_t     o_snoop_flags
);

    dcache_pkg::dc_addr_u          tm_addr;
    logic [`DC_LINE_BYTES-1:0]     tm_wstrb;
    logic [`DC_LINE_WIDTH-1:0]     tm_wline;
    dcache_pkg::dc_flags_t         tm_wflags;
    logic                          tm_hit;
    dcache_pkg::dc_flags_t         tm_rflags;
    logic [`DC_LINE_WIDTH-1:0]     tm_rline;

    dcache_ctrl ctrl_i (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_cpu_req      (i_cpu_req),
        .i_cpu_req_data (i_cpu_req_data),
        .o_cpu_ack      (o_cpu_ack),
        .o_cpu_rsp      (o_cpu_rsp),
        .o_mem_req      (o_mem_req),
        .o_mem_req_data (o_mem_req_data),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rsp      (i_mem_rsp),
        .o_tm_addr      (tm_addr),
        .o_tm_wstrb     (tm_wstrb),
        .o_tm_wline     (tm_wline),
        .o_tm_wflags    (tm_wflags),
        .i_tm_hit       (tm_hit),
        .i_tm_rflags    (tm_rflags),
        .i_tm_rline     (tm_rline)
    );

    // stored line address is for write-back, which this cache has none of
    tag_mem tag_mem_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_addr        (tm_addr),
        .i_wstrb       (tm_wstrb),
        .i_wline       (tm_wline),
        .i_wflags      (tm_wflags),
        .i_snoop_addr  (i_snoop_addr),
        .o_raddr       (),
        .o_rline       (tm_rline),
        .o_rflags      (tm_rflags),
        .o_hit         (tm_hit),
        .o_snoop_flags (o_snoop_flags)
    );

endmodule

// File: tb/dcache_assertions.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

// checker bound into dcache_top, keeps its own copy of memory and line state
module dcache_assertions (
    input logic                            i_clk,
    input logic                            i_nrst,
    input logic                            i_cpu_req,
    input dcache_pkg::dc_cpu_req_t         i_cpu_req_data,
    input logic                            o_cpu_ack,
    input dcache_pkg::dc_cpu_rsp_t         o_cpu_rsp,
    input logic                            o_mem_req,
    input dcache_pkg::dc_mem_req_t         o_mem_req_data,
    input logic                            i_mem_ack,
    input dcache_pkg::dc_addr_u            i_snoop_addr,
    input dcache_pkg::dc_flags_t           o_snoop_flags,
    input logic [`DC_LINE_BYTES-1:0]       tm_wstrb
);

    localparam int LINES = 1 << `DC_INDEX_BITS;

    logic [7:0]              shadow [0:(1 << `DC_ADDR_BITS)-1];
    logic [`DC_TAG_BITS-1:0] line_tag [LINES];
    dcache_pkg::dc_flags_t   line_flags [LINES];
    int                      fail_cnt;          // read by the testbench
    logic                    seen_req;
    logic                    ack_q;
    logic                    cpu_req_q;
    logic                    mem_req_q;
    logic                    hit_req;           // current read should hit
    logic                    snoop_ok_q;
    int                      lat_cnt;
    int                      wr_cnt;
    dcache_pkg::dc_flags_t   snoop_exp_q;
    dcache_pkg::dc_addr_u    cpu_addr;
    logic [15:0]             word_base;
    logic [31:0]             exp_word;
    logic                    req_hit;

    function automatic logic [7:0] fill_byte(input int a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // flags a snoop of this address should return
    function automatic dcache_pkg::dc_flags_t snoop_expected(input dcache_pkg::dc_addr_u a);
        dcache_pkg::dc_flags_t f;
        f = line_flags[a.fld.index];
        if (!f.valid || line_tag[a.fld.index] != a.fld.tag) begin
            f = '0;
        end
        return f;
    endfunction

    initial begin
        fail_cnt = 0;
        for (int a = 0; a < (1 << `DC_ADDR_BITS); a++) begin
            shadow[a] = fill_byte(a);
        end
        for (int i = 0; i < LINES; i++) begin
            line_tag[i]   = '0;
            line_flags[i] = '0;
        end
    end

    assign cpu_addr  = i_cpu_req_data.addr;
    assign word_base = {cpu_addr.raw[15:2], 2'b00};
    assign exp_word  = {shadow[word_base+3], shadow[word_base+2],
                        shadow[word_base+1], shadow[word_base]};
    assign req_hit   = line_flags[cpu_addr.fld.index].valid &&
                       (line_tag[cpu_addr.fld.index] == cpu_addr.fld.tag);

    always @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            seen_req    <= 1'b0;
            ack_q       <= 1'b0;
            cpu_req_q   <= 1'b0;
            mem_req_q   <= 1'b0;
            hit_req     <= 1'b0;
            snoop_ok_q  <= 1'b0;
            lat_cnt     <= 0;
            wr_cnt      <= 0;
            snoop_exp_q <= '0;
        end else begin
            ack_q       <= o_cpu_ack;
            cpu_req_q   <= i_cpu_req;
            mem_req_q   <= o_mem_req;
            lat_cnt     <= lat_cnt + 1;
            snoop_exp_q <= snoop_expected(i_snoop_addr);
            snoop_ok_q  <= !i_cpu_req && !o_cpu_ack && (tm_wstrb == '0);   // no tag write
            if (i_cpu_req && !cpu_req_q) begin
                seen_req <= 1'b1;
                lat_cnt  <= 0;
                wr_cnt   <= 0;
                hit_req  <= !i_cpu_req_data.we && req_hit;
            end else if (!i_cpu_req) begin
                hit_req <= 1'b0;
            end
            if (o_mem_req && !mem_req_q && i_cpu_req_data.we) begin
                wr_cnt <= wr_cnt + 1;
            end
            // line state follows each finished request
            if (o_cpu_ack && !ack_q) begin
                if (i_cpu_req_data.we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (i_cpu_req_data.wstrb[k]) begin
                            shadow[word_base+k] <= i_cpu_req_data.wdata[8*k +: 8];
                        end
                    end
                    if (req_hit) begin
                        line_flags[cpu_addr.fld.index].modified <= 1'b1;
                    end
                end else if (!req_hit) begin
                    line_tag[cpu_addr.fld.index]   <= cpu_addr.fld.tag;
                    line_flags[cpu_addr.fld.index] <= 2'b10;   // valid, clean
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !seen_req |-> !o_cpu_ack && !o_mem_req)
        else begin
            fail_cnt++;
            $error("[ERROR] reset_quiet expected ack=0 mem_req=0 actual ack=%b mem_req=%b",
                   $sampled(o_cpu_ack), $sampled(o_mem_req));
        end

    a_read_data: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(o_cpu_ack) && !i_cpu_req_data.we |-> o_cpu_rsp.rdata == exp_word)
        else begin
            fail_cnt++;
            $error("[ERROR] read_data expected %h actual %h",
                   $sampled(exp_word), $sampled(o_cpu_rsp.rdata));
        end

    a_hit_latency: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(o_cpu_ack) && hit_req |-> lat_cnt == 2)
        else begin
            fail_cnt++;
            $error("[ERROR] hit_latency expected 2 actual %0d", $sampled(lat_cnt));
        end

    a_hit_no_mem: assert property (@(posedge i_clk) disable iff (!i_nrst)
        hit_req |-> !o_mem_req)
        else begin
            fail_cnt++;
            $error("a read hit raised a memory request");
        end

    a_wt_fields: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(o_mem_req) && i_cpu_req_data.we |->
            o_mem_req_data == dcache_pkg::dc_mem_req_t'(i_cpu_req_data))
        else begin
            fail_cnt++;
            $error("[ERROR] write_through expected %h actual %h",
                   $sampled(i_cpu_req_data), $sampled(o_mem_req_data));
        end

    a_wt_count: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(o_cpu_ack) && i_cpu_req_data.we |-> wr_cnt == 1)
        else begin
            fail_cnt++;
            $error("[ERROR] write_count expected 1 actual %0d", $sampled(wr_cnt));
        end

    a_snoop: assert property (@(posedge i_clk) disable iff (!i_nrst)
        snoop_ok_q |-> o_snoop_flags == snoop_exp_q)
        else begin
            fail_cnt++;
            $error("[ERROR] snoop_flags expected %b actual %b",
                   $sampled(snoop_exp_q), $sampled(o_snoop_flags));
        end

    a_cpu_ack_rise: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(o_cpu_ack) |-> i_cpu_req)
        else begin
            fail_cnt++;
            $error("cpu ack rose while cpu req was low");
        end

    a_cpu_req_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cpu_req && !o_cpu_ack |=> i_cpu_req)
        else begin
            fail_cnt++;
            $error("cpu req dropped before cpu ack rose");
        end

    a_cpu_ack_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_cpu_ack && i_cpu_req |=> o_cpu_ack)
        else begin
            fail_cnt++;
            $error("cpu ack dropped while cpu req was still high");
        end

    a_mem_ack_rise: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_mem_ack) |-> o_mem_req)
        else begin
            fail_cnt++;
            $error("memory ack rose while memory req was low");
        end

    a_mem_req_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_mem_req && !i_mem_ack |=> o_mem_req)
        else begin
            fail_cnt++;
            $error("memory req dropped before memory ack rose");
        end

    a_mem_ack_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_mem_ack && o_mem_req |=> i_mem_ack)
        else begin
            fail_cnt++;
            $error("memory ack dropped while memory req was still high");
        end

endmodule

// File: tb/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

    localparam int NUM_REQS       = 300;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 20;

    logic                      i_clk;
    logic                      i_nrst;
    logic                      i_cpu_req;
    dcache_pkg::dc_cpu_req_t   i_cpu_req_data;
    logic                      o_cpu_ack;
    dcache_pkg::dc_cpu_rsp_t   o_cpu_rsp;
    logic                      o_mem_req;
    dcache_pkg::dc_mem_req_t   o_mem_req_data;
    logic                      i_mem_ack;
    dcache_pkg::dc_mem_rsp_t   i_mem_rsp;
    dcache_pkg::dc_addr_u      i_snoop_addr;
    dcache_pkg::dc_flags_t     o_snoop_flags;

    logic [7:0]                mem_bytes [0:(1 << `DC_ADDR_BITS)-1];   // backing memory
    int                        seed;
    int                        cycles;
    int                        mem_delay;
    int                        mem_wait;
    dcache_pkg::dc_addr_u      last_addr;

    dcache_top dcache_top_i (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_cpu_req      (i_cpu_req),
        .i_cpu_req_data (i_cpu_req_data),
        .o_cpu_ack      (o_cpu_ack),
        .o_cpu_rsp      (o_cpu_rsp),
        .o_mem_req      (o_mem_req),
        .o_mem_req_data (o_mem_req_data),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rsp      (i_mem_rsp),
        .i_snoop_addr   (i_snoop_addr),
        .o_snoop_flags  (o_snoop_flags)
    );

    bind dcache_top dcache_assertions chk_i (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_cpu_req      (i_cpu_req),
        .i_cpu_req_data (i_cpu_req_data),
        .o_cpu_ack      (o_cpu_ack),
        .o_cpu_rsp      (o_cpu_rsp),
        .o_mem_req      (o_mem_req),
        .o_mem_req_data (o_mem_req_data),
        .i_mem_ack      (i_mem_ack),
        .i_snoop_addr   (i_snoop_addr),
        .o_snoop_flags  (o_snoop_flags),
        .tm_wstrb       (tm_wstrb)
    );

    function automatic logic [7:0] fill_byte(input int a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("simulation timed out before all requests finished");
            $display("=== FAIL ===");
            $finish;
        end
    end

    // snoop alternates between the current request line and a walking address
    always @(posedge i_clk) begin
        if (cycles[0]) begin
            i_snoop_addr <= i_cpu_req_data.addr;
        end else begin
            i_snoop_addr.raw <= 16'(cycles * 16'h9e37);
        end
    end

    // backing memory answers after mem_delay cycles
    always @(posedge i_clk) begin : mem_model
        logic [15:0]               base;
        logic [`DC_LINE_WIDTH-1:0] line;
        if (o_mem_req && !i_mem_ack) begin
            if (mem_wait >= mem_delay) begin
                base = o_mem_req_data.addr.raw;
                if (o_mem_req_data.we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (o_mem_req_data.wstrb[k]) begin
                            mem_bytes[base+k] = o_mem_req_data.wdata[8*k +: 8];
                        end
                    end
                end else begin
                    for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                        line[8*b +: 8] = mem_bytes[base+b];
                    end
                    i_mem_rsp.line <= line;
                end
                i_mem_ack <= 1'b1;
                mem_wait  <= 0;
            end else begin
                mem_wait <= mem_wait + 1;
            end
        end else if (!o_mem_req && i_mem_ack) begin
            i_mem_ack <= 1'b0;
        end
    end

    task automatic do_request();
        dcache_pkg::dc_cpu_req_t req;
        logic [31:0]             r;
        logic [31:0]             a;
        r = $random(seed);
        a = $random(seed);
        req.we = (r[1:0] == 2'b00);
        if (r[2]) begin
            req.addr = last_addr;                 // same line, likely a hit
            req.addr.raw[3:2] = r[4:3];
        end else begin
            req.addr.raw = a[15:0];
            req.addr.fld.tag[7:2] = '0;           // few tags so lines get reused
        end
        req.addr.raw[1:0] = 2'b00;
        req.wdata = $random(seed);
        req.wstrb = r[8:5];
        if (req.wstrb == '0) begin
            req.wstrb = 4'hf;
        end
        mem_delay = int'(r[10:9]);
        last_addr = req.addr;
        @(posedge i_clk);
        i_cpu_req      <= 1'b1;
        i_cpu_req_data <= req;
        do @(posedge i_clk); while (!o_cpu_ack);
        i_cpu_req <= 1'b0;
        do @(posedge i_clk); while (o_cpu_ack);
    endtask

    initial begin
        seed           = 32'h44c294d7;
        cycles         = 0;
        mem_delay      = 0;
        mem_wait       = 0;
        last_addr      = '0;
        i_nrst         = 1'b0;
        i_cpu_req      = 1'b0;
        i_cpu_req_data = '0;
        i_mem_ack      = 1'b0;
        i_mem_rsp      = '0;
        i_snoop_addr   = '0;
        for (int a = 0; a < (1 << `DC_ADDR_BITS); a++) begin
            mem_bytes[a] = fill_byte(a);
        end
        repeat (4) @(posedge i_clk);
        i_nrst <= 1'b1;
        repeat (20) @(posedge i_clk);             // valid sweep runs 16 cycles
        for (int n = 0; n < NUM_REQS; n++) begin
            do_request();
            repeat (2) @(posedge i_clk);          // idle cycles for snoop checks
        end
        repeat (2) @(posedge i_clk);
        $display("requests: %0d, errors: %0d", NUM_REQS, dcache_top_i.chk_i.fail_cnt);
        if (dcache_top_i.chk_i.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: dcache_lite.f
+incdir+include
hw/dcache_pkg.sv
hw/ram_sync.sv
hw/ram_sync_bwe.sv
hw/tag_mem.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/dcache_assertions.sv
tb/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dcache_lite simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb \
    -f dcache_lite.f \
    --Mdir obj_dir -o dcache_sim

./obj_dir/dcache_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
